// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := xv_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/xv_assertions.sv ====
module xv_assertions (
    input logic pclk,
    input logic rst_n_i,                            // board reset, active low
    input logic core_rst_i,                         // stretched core reset
    input logic wr_stb_i,
    input logic soft_rst_i,
    input logic rx_strobe_i,
    input logic tx_strobe_i,
    input logic spi_cs_n_i,                         // raw pin
    input logic spi_cipo_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // register block is frozen while the core is held
    assert property (@(posedge pclk) disable iff (!rst_n_i)
        core_rst_i |-> !wr_stb_i)
        else $error("register write strobe during core reset");

    assert property (@(posedge pclk) disable iff (!rst_n_i)
        wr_stb_i |=> !wr_stb_i)
        else $error("wr_stb longer than one cycle");

    assert property (@(posedge pclk) disable iff (!rst_n_i)
        soft_rst_i |=> !soft_rst_i)
        else $error("soft_rst longer than one cycle");

    assert property (@(posedge pclk) disable iff (!rst_n_i)
        rx_strobe_i |=> !rx_strobe_i)
        else $error("rx_strobe longer than one cycle");

    assert property (@(posedge pclk) disable iff (!rst_n_i)
        tx_strobe_i |=> !tx_strobe_i)
        else $error("tx_strobe longer than one cycle");

    // CS goes through two sync flops, so allow it three samples
    assert property (@(posedge pclk) disable iff (!rst_n_i)
        (spi_cs_n_i && $past(spi_cs_n_i) && $past(spi_cs_n_i, 2)) |-> spi_cipo_i)
        else $error("CIPO not idle high while deselected");

endmodule

// ==== dv/xv_tb.sv ====
module xv_tb import xv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    HALF      = 8;                // SCK half period in pclk cycles
    localparam byte_t IDLE_RESP = 8'hcb;            // first byte back on every transfer
    localparam int    NUM_ROWS  = 22;
    localparam int    WATCHDOG_CYCLES = 3 * (2 ** RESET_CNT_W)
                                      + (NUM_ROWS + 2 * NUM_REGS) * 40 * HALF + 2000;

    typedef enum logic [1:0] {cmd_write, cmd_read, cmd_soft_reset} kind_e;

    typedef struct packed {
        kind_e    kind;
        reg_num_t reg_num;
        logic     bytesel;                          // 0 upper lane, 1 lower lane
        logic     abort;                            // raise CS after the command byte
    } row_t;

    logic  pclk;
    logic  rst_n_i;
    logic  pll_lock_i;
    logic  spi_sck_i;
    logic  spi_copi_i;
    logic  spi_cs_n_i;
    logic  spi_cipo_o;
    logic  ready_o;
    word_t ctrl_o;

    word_t       model [NUM_REGS];                  // expected register contents
    logic [31:0] rng_state;

    row_t rows [NUM_ROWS] = '{
        '{cmd_write,      4'd0,  1'b0, 1'b0},       // both lanes of the control word
        '{cmd_write,      4'd0,  1'b1, 1'b0},
        '{cmd_read,       4'd0,  1'b0, 1'b0},
        '{cmd_read,       4'd0,  1'b1, 1'b0},
        '{cmd_write,      4'd3,  1'b1, 1'b0},       // lower lane only
        '{cmd_read,       4'd3,  1'b0, 1'b0},       // upper lane still zero
        '{cmd_read,       4'd3,  1'b1, 1'b0},
        '{cmd_write,      4'd3,  1'b0, 1'b0},
        '{cmd_read,       4'd3,  1'b1, 1'b0},       // lower lane untouched by that write
        '{cmd_read,       4'd3,  1'b0, 1'b0},       // upper lane took the new byte
        '{cmd_write,      4'd15, 1'b0, 1'b0},
        '{cmd_write,      4'd15, 1'b1, 1'b0},
        '{cmd_write,      4'd7,  1'b0, 1'b1},       // half command, dropped
        '{cmd_read,       4'd7,  1'b0, 1'b0},
        '{cmd_write,      4'd0,  1'b1, 1'b1},       // control word must not move
        '{cmd_read,       4'd15, 1'b0, 1'b0},
        '{cmd_read,       4'd15, 1'b1, 1'b0},
        '{cmd_write,      4'd0,  1'b0, 1'b0},
        '{cmd_soft_reset, 4'd0,  1'b0, 1'b1},
        '{cmd_read,       4'd0,  1'b0, 1'b0},
        '{cmd_write,      4'd9,  1'b1, 1'b0},
        '{cmd_read,       4'd9,  1'b1, 1'b0}
    };

    xv_top i_xv_top (
        .pclk       (pclk),
        .rst_n_i    (rst_n_i),
        .pll_lock_i (pll_lock_i),
        .spi_sck_i  (spi_sck_i),
        .spi_copi_i (spi_copi_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_cipo_o (spi_cipo_o),
        .ready_o    (ready_o),
        .ctrl_o     (ctrl_o)
    );

    bind xv_top xv_assertions i_xv_assertions (
        .pclk        (pclk),
        .rst_n_i     (rst_n_i),
        .core_rst_i  (core_rst),
        .wr_stb_i    (wr_stb),
        .soft_rst_i  (soft_rst),
        .rx_strobe_i (rx_strobe),
        .tx_strobe_i (tx_strobe),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_cipo_i  (spi_cipo_o)
    );

    always #50 pclk = ~pclk;                        // 100 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic byte_t lane_of(input word_t w, input logic bytesel);
        return bytesel ? w[7:0] : w[15:8];          // lane 0 is the upper byte
    endfunction

    // every drive lands 5 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge pclk);
        #5;
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (ready_o !== 1'b1 && n < limit) begin
            wait_cycles(1);
            n++;
        end
        if (ready_o !== 1'b1) begin
            fail_run($sformatf("ready_o stayed low for %0d cycles after reset", limit));
        end
    endtask

    // mode 0 host, COPI set a half period ahead, CIPO taken at each rising SCK
    task automatic spi_xfer(input byte_t cmd, input byte_t dat, input logic abort,
                            output byte_t resp0, output byte_t resp1);
        byte_t tx;
        byte_t rx;
        int    nbytes;
        nbytes = abort ? 1 : 2;
        resp0 = '0;
        resp1 = '0;
        spi_cs_n_i = 1'b0;
        wait_cycles(HALF);                          // room for the first tx load
        for (int b = 0; b < nbytes; b++) begin
            tx = (b == 0) ? cmd : dat;
            rx = '0;
            repeat (8) begin
                spi_copi_i = tx[7];
                tx = tx << 1;
                wait_cycles(HALF);
                spi_sck_i = 1'b1;
                rx = {rx[6:0], spi_cipo_o};
                wait_cycles(HALF);
                spi_sck_i = 1'b0;
            end
            if (b == 0) begin
                resp0 = rx;
            end else begin
                resp1 = rx;
            end
        end
        wait_cycles(HALF);
        spi_cs_n_i = 1'b1;
        wait_cycles(HALF);                          // CS idle gap between commands
    endtask

    task automatic read_all_regs();
        reg_num_t rn;
        byte_t    r0;
        byte_t    r1;
        for (int r = 0; r < NUM_REGS; r++) begin
            rn = 4'(r);
            for (int b = 0; b < 2; b++) begin
                spi_xfer({1'b0, 2'b00, 1'(b), rn}, 8'h00, 1'b0, r0, r1);
                check("first response byte", {8'h00, r0}, {8'h00, IDLE_RESP});
                check($sformatf("reg %0d lane %0d", r, b), {8'h00, r1},
                      {8'h00, lane_of(model[rn], 1'(b))});
            end
        end
    endtask

    task automatic run_row(input row_t row);
        byte_t cmd;
        byte_t dat;
        byte_t r0;
        byte_t r1;
        case (row.kind)
            cmd_write: cmd = {1'b1, 2'b00, row.bytesel, row.reg_num};
            cmd_read:  cmd = {1'b0, 2'b00, row.bytesel, row.reg_num};
            default:   cmd = 8'h60;                 // both mode bits set
        endcase
        rng_state = next_random(rng_state);
        dat = rng_state[7:0];
        spi_xfer(cmd, dat, row.abort, r0, r1);
        check("first response byte", {8'h00, r0}, {8'h00, IDLE_RESP});
        if (row.kind == cmd_soft_reset) begin
            check("ready_o", {15'd0, ready_o}, 16'd0);  // core went down
            wait_ready(2 ** RESET_CNT_W + 8);
            model = '{default: '0};
            read_all_regs();
        end else if (!row.abort) begin
            if (row.kind == cmd_write) begin
                if (row.bytesel) begin
                    model[row.reg_num][7:0] = dat;
                end else begin
                    model[row.reg_num][15:8] = dat;
                end
            end else begin
                check($sformatf("read reg %0d lane %0d", row.reg_num, row.bytesel),
                      {8'h00, r1}, {8'h00, lane_of(model[row.reg_num], row.bytesel)});
            end
        end
        check("ctrl_o", ctrl_o, model[0]);
        check("ready_o", {15'd0, ready_o}, 16'd1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pclk);
        fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        pclk       = 1'b0;
        rst_n_i    = 1'b0;
        pll_lock_i = 1'b1;
        spi_sck_i  = 1'b0;                          // mode 0 idle
        spi_copi_i = 1'b0;
        spi_cs_n_i = 1'b1;
        rng_state  = 32'h52753747;
        model      = '{default: '0};
        wait_cycles(4);
        rst_n_i = 1'b1;
        check("ready_o", {15'd0, ready_o}, 16'd0);
        wait_ready(2 ** RESET_CNT_W + 4);
        check("ctrl_o", ctrl_o, 16'h0000);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== logic/reg_file.sv ====
module reg_file import xv_pkg::*; (
    input  logic     pclk,
    input  logic     rst_i,                         // core reset, active high
    input  bus_req_t bus_req_i,                     // register, lane and data
    input  logic     wr_stb_i,                      // write the selected lane
    output byte_t    rd_byte_o,                     // selected lane, combinational
    output word_t    ctrl_o                         // register 0
);

    word_t regs [NUM_REGS];                         // stands in for the core register block
    word_t rd_word;                                 // addressed register

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                      // everything reads zero after reset
            end
        end else if (wr_stb_i) begin
            if (bus_req_i.bytesel) begin
                regs[bus_req_i.reg_num][BYTE_W-1:0] <= bus_req_i.data;      // odd byte
            end else begin
                regs[bus_req_i.reg_num][REG_W-1:BYTE_W] <= bus_req_i.data;  // even byte
            end
        end
    end

    assign rd_word = regs[bus_req_i.reg_num];

    // lane 0 is the upper byte, big endian like the host side
    assign rd_byte_o = bus_req_i.bytesel ? rd_word[BYTE_W-1:0] : rd_word[REG_W-1:BYTE_W];

    assign ctrl_o = regs[0];

endmodule

// ==== logic/reset_stretch.sv ====
module reset_stretch import xv_pkg::*; (
    input  logic pclk,
    input  logic rst_n_i,                           // board button, active low
    input  logic pll_lock_i,                        // clock is stable when high
    input  logic soft_rst_i,                        // one-cycle pulse from the SPI bridge
    output logic core_rst_o                         // active high core reset
);

    logic [RESET_CNT_W-1:0] stretch_cnt;            // cycles since all sources went quiet
    logic                   any_rst;                // some reset source active now

    assign any_rst = !rst_n_i || !pll_lock_i || soft_rst_i;

    always_ff @(posedge pclk) begin
        if (any_rst) begin
            stretch_cnt <= '0;                      // restart the stretch
            core_rst_o  <= 1'b1;
        end else if (!(&stretch_cnt)) begin
            stretch_cnt <= stretch_cnt + 1'b1;      // keep counting toward release
            core_rst_o  <= 1'b1;
        end else begin
            core_rst_o  <= 1'b0;                    // counter full, let the core run
        end
    end

endmodule

// ==== logic/spi_bus_bridge.sv ====
module spi_bus_bridge import xv_pkg::*; (
    input  logic     pclk,
    input  logic     rst_i,                         // core reset, active high
    input  logic     select_i,                      // SPI CS active
    input  logic     rx_strobe_i,                   // byte arrived
    input  byte_t    rx_byte_i,
    input  byte_t    rd_byte_i,                     // register byte for the current request
    output byte_t    tx_byte_o,                     // next byte for the host
    output bus_req_t bus_req_o,                     // held until the next command
    output logic     wr_stb_o,                      // one-cycle write pulse
    output logic     soft_rst_o                     // one-cycle reset request
);

    logic  second_byte;                             // high after a command byte
    logic  is_soft_rst;                             // command byte has both mode bits
    logic  cmd_stb;                                 // command byte this cycle
    logic  data_stb;                                // data byte this cycle

    assign is_soft_rst = (rx_byte_i & CMD_SOFT_RESET_MASK) == CMD_SOFT_RESET_MASK;
    assign cmd_stb     = select_i && rx_strobe_i && !second_byte;
    assign data_stb    = select_i && rx_strobe_i && second_byte;

    // idle byte first, then whatever the command addresses
    assign tx_byte_o = second_byte ? rd_byte_i : RESP_IDLE;

    always_ff @(posedge pclk) begin
        if (rst_i || !select_i) begin
            second_byte <= 1'b0;                    // CS drop discards a half command
            wr_stb_o    <= 1'b0;
            soft_rst_o  <= 1'b0;
        end else begin
            wr_stb_o   <= 1'b0;
            soft_rst_o <= 1'b0;
            if (cmd_stb) begin
                second_byte <= 1'b1;
                soft_rst_o  <= is_soft_rst;         // reset takes the core down itself
            end
            if (data_stb) begin
                second_byte <= 1'b0;                // back to command phase
                wr_stb_o    <= !bus_req_o.rd_nwr;   // reads only shift out
            end
        end
    end

    // request fields are payload, updated on byte arrival only
    always_ff @(posedge pclk) begin
        if (cmd_stb) begin
            bus_req_o.rd_nwr  <= !rx_byte_i[CMD_WRITE_BIT];
            bus_req_o.bytesel <= rx_byte_i[CMD_BYTESEL_BIT];
            bus_req_o.reg_num <= rx_byte_i[CMD_REG_MSB:0];
        end
        if (data_stb) begin
            bus_req_o.data <= rx_byte_i;            // lands with wr_stb
        end
    end

endmodule

// ==== logic/spi_target.sv ====
module spi_target import xv_pkg::*; (
    input  logic  pclk,
    input  logic  rst_i,                            // core reset, active high
    input  logic  spi_sck_i,                        // mode 0 clock from host
    input  logic  spi_copi_i,                       // host data in
    input  logic  spi_cs_n_i,                       // chip select, active low
    output logic  spi_cipo_o,                       // data back to host
    output logic  select_o,                         // synchronized CS level
    output logic  rx_strobe_o,                      // byte received pulse
    output byte_t rx_byte_o,                        // received byte, valid at rx_strobe
    output logic  tx_strobe_o,                      // next tx byte is loaded now
    input  byte_t tx_byte_i                         // byte to send next
);

    logic [2:0]           sck_sync;                 // [1:0] synchronizer, [2] edge history
    logic [2:0]           cs_n_sync;                // same layout for CS
    logic [1:0]           copi_sync;                // data only needs the two stages
    logic                 sck_rise;
    logic                 sck_fall;
    logic                 sel_rise;                 // CS just became active
    logic                 sample_en;                // take COPI this cycle
    logic [BIT_CNT_W-1:0] bit_cnt;                  // bits of the current byte
    byte_t                rx_shift;
    byte_t                tx_shift;

    assign sck_rise = sck_sync[1] && !sck_sync[2];
    assign sck_fall = !sck_sync[1] && sck_sync[2];
    assign select_o = !cs_n_sync[1];
    assign sel_rise = !cs_n_sync[1] && cs_n_sync[2];

    // MSB of the shifter goes out, idle high while deselected
    assign spi_cipo_o = select_o ? tx_shift[BYTE_W-1] : 1'b1;

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            sck_sync    <= '0;                      // SCK idles low in mode 0
            cs_n_sync   <= '1;                      // deselected
            copi_sync   <= '0;
            sample_en   <= 1'b0;
            bit_cnt     <= '0;
            rx_strobe_o <= 1'b0;
            tx_strobe_o <= 1'b0;
        end else begin
            sck_sync    <= {sck_sync[1:0], spi_sck_i};
            cs_n_sync   <= {cs_n_sync[1:0], spi_cs_n_i};
            copi_sync   <= {copi_sync[0], spi_copi_i};
            sample_en   <= sck_rise && select_o;    // sample one cycle after the edge
            rx_strobe_o <= 1'b0;
            // first byte on select, then one cycle behind each received byte
            tx_strobe_o <= select_o && (sel_rise || rx_strobe_o);
            if (!select_o) begin
                bit_cnt <= '0;                      // deselect aborts the byte
            end else if (sample_en) begin
                bit_cnt <= bit_cnt + 1'b1;          // wraps after the eighth bit
                if (&bit_cnt) begin
                    rx_strobe_o <= 1'b1;
                end
            end
        end
    end

    // shift registers, no reset needed
    always_ff @(posedge pclk) begin
        if (sample_en) begin
            rx_shift <= {rx_shift[BYTE_W-2:0], copi_sync[1]};   // MSB first
            if (&bit_cnt) begin
                rx_byte_o <= {rx_shift[BYTE_W-2:0], copi_sync[1]};
            end
        end
        if (!select_o) begin
            tx_shift <= '1;
        end else if (tx_strobe_o) begin
            tx_shift <= tx_byte_i;                  // MSB on the pin before the first rise
        end else if (sck_fall && bit_cnt != '0) begin
            // the fall after the last bit keeps the freshly loaded MSB
            tx_shift <= {tx_shift[BYTE_W-2:0], 1'b1};
        end
    end

endmodule

// ==== logic/xv_pkg.sv ====
package xv_pkg;

    // register bus geometry
    localparam int NUM_REGS    = 16;                // word registers on the bus
    localparam int REG_W       = 16;                // bits per register
    localparam int REG_NUM_W   = 4;                 // register index width
    localparam int BYTE_W      = 8;                 // bus and SPI data width

    // reset stretcher, core stays in reset for 2**RESET_CNT_W cycles
    localparam int RESET_CNT_W = 8;

    // SPI bit counter, one byte per wrap
    localparam int BIT_CNT_W   = 3;

    // command byte layout: W M1 M0 BS R3 R2 R1 R0
    localparam int CMD_WRITE_BIT   = 7;             // 1 = write, 0 = read
    localparam int CMD_BYTESEL_BIT = 4;             // 0 = even (upper) byte, 1 = odd (lower)
    localparam int CMD_REG_MSB     = REG_NUM_W - 1; // register index sits in the low bits

    localparam logic [BYTE_W-1:0] CMD_SOFT_RESET_MASK = 8'h60;  // both mode bits set

    // first response byte while the command shifts in
    localparam logic [BYTE_W-1:0] RESP_IDLE = 8'hcb;

    typedef logic [REG_NUM_W-1:0] reg_num_t;        // register index
    typedef logic [BYTE_W-1:0]    byte_t;           // one data byte
    typedef logic [REG_W-1:0]     word_t;           // one register word

    // one register access, bridge -> register file
    typedef struct packed {
        logic     rd_nwr;                           // read high, write low
        logic     bytesel;                          // byte lane select
        reg_num_t reg_num;                          // target register
        byte_t    data;                             // write data
    } bus_req_t;

endpackage

// ==== logic/xv_top.sv ====
module xv_top import xv_pkg::*; (
    input  logic  pclk,                             // pixel clock
    input  logic  rst_n_i,                          // board button, active low
    input  logic  pll_lock_i,                       // PLL locked
    input  logic  spi_sck_i,
    input  logic  spi_copi_i,
    input  logic  spi_cs_n_i,
    output logic  spi_cipo_o,
    output logic  ready_o,                          // core out of reset
    output word_t ctrl_o                            // control word from register 0
);

    logic     core_rst;                             // stretched core reset
    logic     soft_rst;                             // SPI soft reset pulse
    logic     select;
    logic     rx_strobe;
    byte_t    rx_byte;
    logic     tx_strobe;
    byte_t    tx_byte;
    bus_req_t bus_req;
    logic     wr_stb;
    byte_t    rd_byte;

    assign ready_o = !core_rst;

    reset_stretch i_reset_stretch (
        .pclk       (pclk),
        .rst_n_i    (rst_n_i),
        .pll_lock_i (pll_lock_i),
        .soft_rst_i (soft_rst),
        .core_rst_o (core_rst)
    );

    spi_target i_spi_target (
        .pclk        (pclk),
        .rst_i       (core_rst),
        .spi_sck_i   (spi_sck_i),
        .spi_copi_i  (spi_copi_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_cipo_o  (spi_cipo_o),
        .select_o    (select),
        .rx_strobe_o (rx_strobe),
        .rx_byte_o   (rx_byte),
        .tx_strobe_o (tx_strobe),
        .tx_byte_i   (tx_byte)
    );

    spi_bus_bridge i_spi_bus_bridge (
        .pclk        (pclk),
        .rst_i       (core_rst),
        .select_i    (select),
        .rx_strobe_i (rx_strobe),
        .rx_byte_i   (rx_byte),
        .rd_byte_i   (rd_byte),
        .tx_byte_o   (tx_byte),
        .bus_req_o   (bus_req),
        .wr_stb_o    (wr_stb),
        .soft_rst_o  (soft_rst)
    );

    reg_file i_reg_file (
        .pclk      (pclk),
        .rst_i     (core_rst),
        .bus_req_i (bus_req),
        .wr_stb_i  (wr_stb),
        .rd_byte_o (rd_byte),
        .ctrl_o    (ctrl_o)
    );

endmodule

// ==== sources.f ====
logic/xv_pkg.sv
logic/reset_stretch.sv
logic/spi_target.sv
logic/spi_bus_bridge.sv
logic/reg_file.sv
logic/xv_top.sv
dv/xv_assertions.sv
dv/xv_tb.sv
